/* Makefile */
BIN     := obj_dir/Vtb_fp_forwarding_unit
SOURCES := $(wildcard rtl/*.sv dv/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): build.f $(SOURCES)
	verilator --binary --timing --assert --top-module tb_fp_forwarding_unit -f build.f

# The run passes only if the pass line appears in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir

/* build.f */
rtl/fp_fwd_pkg.sv
rtl/fwd_hazard_ctrl.sv
rtl/load_capture_buf.sv
rtl/fwd_operand_path.sv
rtl/fp_forwarding_unit.sv
dv/fp_fwd_props.sv
dv/tb_fp_forwarding_unit.sv

/* dv/fp_fwd_props.sv */
`timescale 1ns/1ps
`default_nettype none

module fwd_hazard_props (
  input logic i_clk,
  input logic i_reset,
  input logic i_flush,
  input logic i_capture,
  input logic i_stall_fwd_pipe
);

  // ==========================================================
  // Stall pulse shape
  // ==========================================================

  // The staged-load stall lasts one cycle and never repeats back to back
  assert property (@(posedge i_clk) disable iff (i_reset)
    i_stall_fwd_pipe |=> !i_stall_fwd_pipe)
    else $error("stall pulse held for two consecutive cycles");

  // Reset leaves the stall low on the following cycle
  assert property (@(posedge i_clk) i_reset |=> !i_stall_fwd_pipe)
    else $error("stall high in the cycle after reset");

  // A capture that is not cancelled by reset or flush raises the stall next
  assert property (@(posedge i_clk)
    (i_capture && !i_flush && !i_reset) |=> i_stall_fwd_pipe)
    else $error("capture strobe not followed by a stall pulse");

endmodule

bind fwd_hazard_ctrl fwd_hazard_props u_props (
  .i_clk            (i_clk),
  .i_reset          (i_reset),
  .i_flush          (i_ctrl.flush),
  .i_capture        (o_capture),
  .i_stall_fwd_pipe (o_stall_fwd_pipe)
);

`default_nettype wire

/* dv/tb_fp_forwarding_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fp_forwarding_unit;

  localparam int FLEN         = 64;
  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_CYCLES   = 3000;
  // Whole run length with a generous margin for the watchdog
  localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_CYCLES + 10) * CLK_PERIOD * 3;
  localparam logic [31:0] SEED = 32'hc739_d3b8;

  // Operand source codes private to the reference model
  localparam int SRC_RF        = 0;
  localparam int SRC_MA_LOAD   = 1;
  localparam int SRC_MA_RESULT = 2;
  localparam int SRC_WB        = 3;
  localparam int SRC_BUF       = 4;

  logic                   i_clk;
  logic                   i_reset;
  fp_fwd_pkg::pipe_ctrl_t i_ctrl;
  fp_fwd_pkg::fp_instr_u  i_ex_instr;
  logic [FLEN-1:0]        i_rf_rs1;
  logic [FLEN-1:0]        i_rf_rs2;
  logic [FLEN-1:0]        i_rf_rs3;
  fp_fwd_pkg::ma_info_t   i_ma;
  logic [FLEN-1:0]        i_ma_result;
  logic [FLEN-1:0]        i_ma_load_data;
  logic                   i_ma_load_valid;
  fp_fwd_pkg::wb_info_t   i_wb;
  logic [FLEN-1:0]        i_wb_data;
  logic [FLEN-1:0]        o_rs1_value;
  logic [FLEN-1:0]        o_rs2_value;
  logic [FLEN-1:0]        o_rs3_value;
  logic                   o_stall_fwd_pipe;

  fp_forwarding_unit #(
    .FLEN (FLEN)
  ) dut (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_ctrl           (i_ctrl),
    .i_ex_instr       (i_ex_instr),
    .i_rf_rs1         (i_rf_rs1),
    .i_rf_rs2         (i_rf_rs2),
    .i_rf_rs3         (i_rf_rs3),
    .i_ma             (i_ma),
    .i_ma_result      (i_ma_result),
    .i_ma_load_data   (i_ma_load_data),
    .i_ma_load_valid  (i_ma_load_valid),
    .i_wb             (i_wb),
    .i_wb_data        (i_wb_data),
    .o_rs1_value      (o_rs1_value),
    .o_rs2_value      (o_rs2_value),
    .o_rs3_value      (o_rs3_value),
    .o_stall_fwd_pipe (o_stall_fwd_pipe)
  );

  initial i_clk = 1'b0;
  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  // ==========================================================
  // Reference model state
  // ==========================================================

  logic                             m_pending    = 1'b0;
  logic                             m_use_staged = 1'b0;
  logic [FLEN-1:0]                  m_stage1     = '0;
  logic [FLEN-1:0]                  m_stage2     = '0;
  logic                             m_buf_valid  = 1'b0;
  logic                             m_buf_clear  = 1'b0;
  logic [fp_fwd_pkg::REG_IDX_W-1:0] m_buf_dest   = '0;
  logic [FLEN-1:0]                  m_buf_data   = '0;

  // Hit counters, so a quiet run cannot pass without touching each path
  int stall_pulses = 0;
  int staged_hits  = 0;
  int buf_hits     = 0;

  // Stop at the first difference between model and DUT
  task automatic check_value(input string name, input logic [FLEN-1:0] expected,
                             input logic [FLEN-1:0] actual);
    if (expected !== actual) begin
      $display("Mismatch in %s at %0t: expected %h, actual %h", name, $time,
               expected, actual);
      $display("FAIL: see errors above");
      $fatal(1, "first error reached");
    end
  endtask

  // Advance the model by one clock edge using the inputs of the ending cycle
  task automatic model_step();
    logic capture;
    logic buf_fill;
    logic clr;
    capture  = i_ctrl.load_use_stall && i_ma.is_load && !m_pending;
    buf_fill = i_ma.is_load && i_ma_load_valid;
    clr      = i_reset || i_ctrl.flush;
    // Stage 2 copies the old stage 1 during the stall pulse
    if (m_pending) m_stage2 = m_stage1;
    if (capture) m_stage1 = i_ma_load_data;
    // Staged data starts after the pulse and ends on the first free cycle
    if (clr) m_use_staged = 1'b0;
    else if (m_pending) m_use_staged = 1'b1;
    else if (m_use_staged && !i_ctrl.stall) m_use_staged = 1'b0;
    m_pending = clr ? 1'b0 : capture;
    // Buffer expiry: arm clear on the first unstalled cycle, drop one later
    if (clr) begin
      m_buf_valid = 1'b0;
      m_buf_clear = 1'b0;
    end else if (buf_fill) begin
      m_buf_valid = 1'b1;
      m_buf_clear = 1'b0;
    end else if (m_buf_valid && m_buf_clear) begin
      m_buf_valid = 1'b0;
      m_buf_clear = 1'b0;
    end else if (m_buf_valid && !i_ctrl.stall) begin
      m_buf_clear = 1'b1;
    end
    if (buf_fill) begin
      m_buf_dest = i_ma.dest;
      m_buf_data = i_ma_load_data;
    end
  endtask

  // Youngest matching producer wins, register file is the fallback
  function automatic int operand_source(input logic [fp_fwd_pkg::REG_IDX_W-1:0] src);
    if (i_ma.is_load && i_ma.dest == src) return SRC_MA_LOAD;
    if (i_ma.write_en && !i_ma.is_load && i_ma.dest == src) return SRC_MA_RESULT;
    if (i_wb.write_en && i_wb.dest == src) return SRC_WB;
    if (m_buf_valid && m_buf_dest == src) return SRC_BUF;
    return SRC_RF;
  endfunction

  function automatic logic [FLEN-1:0] operand_value(input int src, input logic [FLEN-1:0] rf);
    case (src)
      SRC_MA_LOAD:   return m_use_staged ? m_stage2 : i_ma_load_data;
      SRC_MA_RESULT: return i_ma_result;
      SRC_WB:        return i_wb_data;
      SRC_BUF:       return m_buf_data;
      default:       return rf;
    endcase
  endfunction

  function automatic logic uses_rs3(input logic [fp_fwd_pkg::OPC_W-1:0] opcode);
    return opcode == fp_fwd_pkg::OPC_FMADD || opcode == fp_fwd_pkg::OPC_FMSUB ||
           opcode == fp_fwd_pkg::OPC_FNMSUB || opcode == fp_fwd_pkg::OPC_FNMADD;
  endfunction

  task automatic check_outputs();
    int src1;
    int src2;
    int src3;
    src1 = operand_source(i_ex_instr.r.rs1);
    src2 = operand_source(i_ex_instr.r.rs2);
    // Non-FMA opcodes carry funct7 bits where rs3 would sit
    src3 = uses_rs3(i_ex_instr.r4.opcode) ? operand_source(i_ex_instr.r4.rs3) : SRC_RF;
    check_value("stall_pulse", FLEN'(m_pending), FLEN'(o_stall_fwd_pipe));
    check_value("rs1_priority", operand_value(src1, i_rf_rs1), o_rs1_value);
    check_value("rs2_priority", operand_value(src2, i_rf_rs2), o_rs2_value);
    check_value("rs3_gating", operand_value(src3, i_rf_rs3), o_rs3_value);
    if (m_pending) stall_pulses++;
    if (src1 == SRC_MA_LOAD && m_use_staged) staged_hits++;
    if (src1 == SRC_BUF) buf_hits++;
  endtask

  // ==========================================================
  // Stimulus
  // ==========================================================

  task automatic drive_idle(input logic reset);
    i_reset         <= reset;
    i_ctrl          <= '0;
    i_ex_instr      <= '0;
    i_rf_rs1        <= '0;
    i_rf_rs2        <= '0;
    i_rf_rs3        <= '0;
    i_ma            <= '0;
    i_ma_result     <= '0;
    i_ma_load_data  <= '0;
    i_ma_load_valid <= 1'b0;
    i_wb            <= '0;
    i_wb_data       <= '0;
  endtask

  // Register indices come from f0 to f3 so that matches are frequent
  task automatic drive_random();
    logic [31:0]            r;
    logic [31:0]            s;
    fp_fwd_pkg::fp_instr_u  instr;
    fp_fwd_pkg::pipe_ctrl_t ctrl;
    fp_fwd_pkg::ma_info_t   ma;
    fp_fwd_pkg::wb_info_t   wb;
    r = $urandom;
    s = $urandom;
    ctrl.stall          = r[3:0] < 4'd4;
    ctrl.load_use_stall = r[7:4] < 4'd5;
    ctrl.flush          = r[11:8] == 4'd0;
    instr.r4.rs3 = {3'b000, r[13:12]};
    instr.r4.fmt = s[1:0];
    instr.r4.rs2 = {3'b000, r[15:14]};
    instr.r4.rs1 = {3'b000, s[3:2]};
    instr.r4.rm  = s[6:4];
    instr.r4.rd  = s[11:7];
    case ({r[16], r[18:17]})
      3'b100:  instr.r4.opcode = fp_fwd_pkg::OPC_FMADD;
      3'b101:  instr.r4.opcode = fp_fwd_pkg::OPC_FMSUB;
      3'b110:  instr.r4.opcode = fp_fwd_pkg::OPC_FNMSUB;
      3'b111:  instr.r4.opcode = fp_fwd_pkg::OPC_FNMADD;
      default: instr.r4.opcode = fp_fwd_pkg::OPC_OP_FP;
    endcase
    ma.is_load   = r[19];
    ma.write_en  = r[19] | r[20];
    ma.dest      = {3'b000, r[22:21]};
    wb.write_en  = r[23];
    wb.dest      = {3'b000, r[25:24]};
    i_reset         <= 1'b0;
    i_ctrl          <= ctrl;
    i_ex_instr      <= instr;
    i_ma            <= ma;
    i_wb            <= wb;
    i_ma_load_valid <= r[26] | r[27];
    i_rf_rs1        <= {$urandom, $urandom};
    i_rf_rs2        <= {$urandom, $urandom};
    i_rf_rs3        <= {$urandom, $urandom};
    i_ma_result     <= {$urandom, $urandom};
    i_ma_load_data  <= {$urandom, $urandom};
    i_wb_data       <= {$urandom, $urandom};
  endtask

  initial begin
    void'($urandom(SEED));
    drive_idle(1'b1);
    for (int cyc = 0; cyc < RESET_CYCLES + NUM_CYCLES; cyc++) begin
      @(posedge i_clk);
      model_step();
      if (cyc < RESET_CYCLES - 1) drive_idle(1'b1);
      else drive_random();
      // Outputs are settled half a period after the drive edge
      @(negedge i_clk);
      check_outputs();
    end
    if (stall_pulses == 0 || staged_hits == 0 || buf_hits == 0) begin
      $display("Stimulus never reached a path: %0d stall pulses, %0d staged hits, %0d buffer hits",
               stall_pulses, staged_hits, buf_hits);
      $display("FAIL: see errors above");
      $fatal(1, "missing path coverage");
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("FAIL: see errors above");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

/* rtl/fp_forwarding_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_forwarding_unit #(
  parameter int FLEN = 64
) (
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  fp_fwd_pkg::pipe_ctrl_t i_ctrl,
  // Instruction currently in EX
  input  fp_fwd_pkg::fp_instr_u  i_ex_instr,
  input  logic [FLEN-1:0]        i_rf_rs1,
  input  logic [FLEN-1:0]        i_rf_rs2,
  input  logic [FLEN-1:0]        i_rf_rs3,
  // MA-stage producer, compute result and load return
  input  fp_fwd_pkg::ma_info_t   i_ma,
  input  logic [FLEN-1:0]        i_ma_result,
  input  logic [FLEN-1:0]        i_ma_load_data,
  input  logic                   i_ma_load_valid,
  // WB-stage producer
  input  fp_fwd_pkg::wb_info_t   i_wb,
  input  logic [FLEN-1:0]        i_wb_data,
  // Resolved operands for the FPU in EX
  output logic [FLEN-1:0]        o_rs1_value,
  output logic [FLEN-1:0]        o_rs2_value,
  output logic [FLEN-1:0]        o_rs3_value,
  output logic                   o_stall_fwd_pipe
);

  fp_fwd_pkg::fwd_sel_t sel;
  fp_fwd_pkg::buf_tag_t buf_tag;
  logic [FLEN-1:0]      buf_data;
  logic                 capture;
  logic                 use_staged;

  // Hazard detection, source priority and the staged-load stall
  fwd_hazard_ctrl u_ctrl (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_ctrl           (i_ctrl),
    .i_ex_instr       (i_ex_instr),
    .i_ma             (i_ma),
    .i_wb             (i_wb),
    .i_buf_tag        (buf_tag),
    .o_sel            (sel),
    .o_capture        (capture),
    .o_use_staged     (use_staged),
    .o_stall_fwd_pipe (o_stall_fwd_pipe)
  );

  // Holds the last completed FP load for late consumers
  load_capture_buf #(
    .FLEN (FLEN)
  ) u_load_buf (
    .i_clk           (i_clk),
    .i_reset         (i_reset),
    .i_ctrl          (i_ctrl),
    .i_ma            (i_ma),
    .i_ma_load_valid (i_ma_load_valid),
    .i_ma_load_data  (i_ma_load_data),
    .o_tag           (buf_tag),
    .o_data          (buf_data)
  );

  // Stage 2 advances while the stall pulse is up, i.e. while pending
  fwd_operand_path #(
    .FLEN (FLEN)
  ) u_path (
    .i_clk          (i_clk),
    .i_sel          (sel),
    .i_capture      (capture),
    .i_advance      (o_stall_fwd_pipe),
    .i_use_staged   (use_staged),
    .i_rf_rs1       (i_rf_rs1),
    .i_rf_rs2       (i_rf_rs2),
    .i_rf_rs3       (i_rf_rs3),
    .i_ma_result    (i_ma_result),
    .i_ma_load_data (i_ma_load_data),
    .i_wb_data      (i_wb_data),
    .i_buf_data     (buf_data),
    .o_rs1_value    (o_rs1_value),
    .o_rs2_value    (o_rs2_value),
    .o_rs3_value    (o_rs3_value)
  );

endmodule

`default_nettype wire

/* rtl/fp_fwd_pkg.sv */
`default_nettype none

package fp_fwd_pkg;

  // ==========================================================
  // Widths and encodings
  // ==========================================================

  // FP register index, f0 to f31 with no hardwired zero
  localparam int REG_IDX_W = 5;
  localparam int OPC_W     = 7;

  // Major opcodes of the four fused multiply-add forms (R4 format)
  localparam logic [OPC_W-1:0] OPC_FMADD  = 7'b1000011;
  localparam logic [OPC_W-1:0] OPC_FMSUB  = 7'b1000111;
  localparam logic [OPC_W-1:0] OPC_FNMSUB = 7'b1001011;
  localparam logic [OPC_W-1:0] OPC_FNMADD = 7'b1001111;
  // Ordinary two-source FP arithmetic, which carries no rs3
  localparam logic [OPC_W-1:0] OPC_OP_FP  = 7'b1010011;

  // Operand source select codes, one per forwarding source
  localparam int SEL_W = 3;
  localparam logic [SEL_W-1:0] SEL_REGFILE   = 3'd0;
  localparam logic [SEL_W-1:0] SEL_MA_LOAD   = 3'd1;
  localparam logic [SEL_W-1:0] SEL_MA_RESULT = 3'd2;
  localparam logic [SEL_W-1:0] SEL_WB        = 3'd3;
  localparam logic [SEL_W-1:0] SEL_LOAD_BUF  = 3'd4;

  // ==========================================================
  // Pipeline and stage descriptors
  // ==========================================================

  // Pipeline control seen by the forwarding unit
  typedef struct packed {
    logic stall;
    logic flush;
    logic load_use_stall;
  } pipe_ctrl_t;

  // Producer sitting in MA, either a compute op or a load
  typedef struct packed {
    logic                 write_en;
    logic                 is_load;
    logic [REG_IDX_W-1:0] dest;
  } ma_info_t;

  // Producer sitting in WB
  typedef struct packed {
    logic                 write_en;
    logic [REG_IDX_W-1:0] dest;
  } wb_info_t;

  // Tag of the one-entry load capture buffer
  typedef struct packed {
    logic                 valid;
    logic [REG_IDX_W-1:0] dest;
  } buf_tag_t;

  // One select code per FP source operand
  typedef struct packed {
    logic [SEL_W-1:0] rs1;
    logic [SEL_W-1:0] rs2;
    logic [SEL_W-1:0] rs3;
  } fwd_sel_t;

  // ==========================================================
  // Instruction word views
  // ==========================================================

  typedef struct packed {
    logic [6:0]           funct7;
    logic [REG_IDX_W-1:0] rs2;
    logic [REG_IDX_W-1:0] rs1;
    logic [2:0]           funct3;
    logic [REG_IDX_W-1:0] rd;
    logic [OPC_W-1:0]     opcode;
  } instr_r_t;

  // In R4 the top five bits of funct7 hold rs3 and the low two hold fmt
  typedef struct packed {
    logic [REG_IDX_W-1:0] rs3;
    logic [1:0]           fmt;
    logic [REG_IDX_W-1:0] rs2;
    logic [REG_IDX_W-1:0] rs1;
    logic [2:0]           rm;
    logic [REG_IDX_W-1:0] rd;
    logic [OPC_W-1:0]     opcode;
  } instr_r4_t;

  typedef union packed {
    instr_r_t  r;
    instr_r4_t r4;
  } fp_instr_u;

endpackage

`default_nettype wire

/* rtl/fwd_hazard_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module fwd_hazard_ctrl (
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  fp_fwd_pkg::pipe_ctrl_t i_ctrl,
  input  fp_fwd_pkg::fp_instr_u  i_ex_instr,
  input  fp_fwd_pkg::ma_info_t   i_ma,
  input  fp_fwd_pkg::wb_info_t   i_wb,
  input  fp_fwd_pkg::buf_tag_t   i_buf_tag,
  output fp_fwd_pkg::fwd_sel_t   o_sel,
  output logic                   o_capture,
  output logic                   o_use_staged,
  output logic                   o_stall_fwd_pipe
);

  // ==========================================================
  // Source register extraction
  // ==========================================================

  logic [fp_fwd_pkg::REG_IDX_W-1:0] src_rs1;
  logic [fp_fwd_pkg::REG_IDX_W-1:0] src_rs2;
  logic [fp_fwd_pkg::REG_IDX_W-1:0] src_rs3;
  logic                             is_fma;

  // rs1 and rs2 sit at the same bits in both formats, so the R view serves
  assign src_rs1 = i_ex_instr.r.rs1;
  assign src_rs2 = i_ex_instr.r.rs2;
  // rs3 only exists in the R4 view, where it overlays funct7[6:2]
  assign src_rs3 = i_ex_instr.r4.rs3;

  // Only the fused multiply-add family actually reads a third operand
  always_comb begin
    case (i_ex_instr.r4.opcode)
      fp_fwd_pkg::OPC_FMADD,
      fp_fwd_pkg::OPC_FMSUB,
      fp_fwd_pkg::OPC_FNMSUB,
      fp_fwd_pkg::OPC_FNMADD: is_fma = 1'b1;
      default:                is_fma = 1'b0;
    endcase
  end

  // ==========================================================
  // Priority source selection
  // ==========================================================

  // Resolve one source register against every producer.
  // The youngest producer wins, so MA beats WB and WB beats the buffer
  function automatic logic [fp_fwd_pkg::SEL_W-1:0] pick_source(
    input logic [fp_fwd_pkg::REG_IDX_W-1:0] src,
    input fp_fwd_pkg::ma_info_t             ma,
    input fp_fwd_pkg::wb_info_t             wb,
    input fp_fwd_pkg::buf_tag_t             tag
  );
    logic [fp_fwd_pkg::SEL_W-1:0] sel;
    sel = fp_fwd_pkg::SEL_REGFILE;
    if (ma.is_load && (ma.dest == src)) begin
      sel = fp_fwd_pkg::SEL_MA_LOAD;
    end else if (ma.write_en && !ma.is_load && (ma.dest == src)) begin
      // A compute op in MA already has its result on the bus
      sel = fp_fwd_pkg::SEL_MA_RESULT;
    end else if (wb.write_en && (wb.dest == src)) begin
      sel = fp_fwd_pkg::SEL_WB;
    end else if (tag.valid && (tag.dest == src)) begin
      // Load has left MA but the consumer may still be waiting in EX
      sel = fp_fwd_pkg::SEL_LOAD_BUF;
    end
    return sel;
  endfunction

  always_comb begin
    o_sel.rs1 = pick_source(src_rs1, i_ma, i_wb, i_buf_tag);
    o_sel.rs2 = pick_source(src_rs2, i_ma, i_wb, i_buf_tag);
    // A non-FMA instruction has funct7 bits there, not a register index
    if (is_fma) begin
      o_sel.rs3 = pick_source(src_rs3, i_ma, i_wb, i_buf_tag);
    end else begin
      o_sel.rs3 = fp_fwd_pkg::SEL_REGFILE;
    end
  end

  // ==========================================================
  // Staged load sequencing
  // ==========================================================

  logic pending;
  logic use_staged;

  // Load data is grabbed into stage 1 while the load-use stall holds it
  // steady, and the pending flag blocks a second grab on the next cycle
  assign o_capture = i_ctrl.load_use_stall && i_ma.is_load && !pending;

  // Pending marks stage 1 full and stage 2 stale for exactly one cycle
  always_ff @(posedge i_clk) begin
    if (i_reset || i_ctrl.flush) begin
      pending <= 1'b0;
    end else begin
      pending <= o_capture;
    end
  end

  // The extra stall gives the data one cycle to move into stage 2
  assign o_stall_fwd_pipe = pending;

  // Stage 2 is valid from the cycle after the move until the consumer
  // finally advances out of EX on an unstalled cycle
  always_ff @(posedge i_clk) begin
    if (i_reset || i_ctrl.flush) begin
      use_staged <= 1'b0;
    end else if (pending) begin
      use_staged <= 1'b1;
    end else if (use_staged && !i_ctrl.stall) begin
      use_staged <= 1'b0;
    end
  end

  assign o_use_staged = use_staged;

endmodule

`default_nettype wire

/* rtl/fwd_operand_path.sv */
`timescale 1ns/1ps
`default_nettype none

module fwd_operand_path #(
  parameter int FLEN = 64
) (
  input  logic                 i_clk,
  input  fp_fwd_pkg::fwd_sel_t i_sel,
  input  logic                 i_capture,
  input  logic                 i_advance,
  input  logic                 i_use_staged,
  input  logic [FLEN-1:0]      i_rf_rs1,
  input  logic [FLEN-1:0]      i_rf_rs2,
  input  logic [FLEN-1:0]      i_rf_rs3,
  input  logic [FLEN-1:0]      i_ma_result,
  input  logic [FLEN-1:0]      i_ma_load_data,
  input  logic [FLEN-1:0]      i_wb_data,
  input  logic [FLEN-1:0]      i_buf_data,
  output logic [FLEN-1:0]      o_rs1_value,
  output logic [FLEN-1:0]      o_rs2_value,
  output logic [FLEN-1:0]      o_rs3_value
);

  // ==========================================================
  // Two-stage load data pipeline
  // ==========================================================

  logic [FLEN-1:0] load_stage1;
  logic [FLEN-1:0] load_stage2;
  logic [FLEN-1:0] ma_load_value;

  // Stage 1 samples memory data while the load-use stall holds it
  always_ff @(posedge i_clk) begin
    if (i_capture) begin
      load_stage1 <= i_ma_load_data;
    end
  end

  // Stage 2 is the copy that fans out to the three operand muxes,
  // so the memory path never drives the wide fanout directly
  always_ff @(posedge i_clk) begin
    if (i_advance) begin
      load_stage2 <= load_stage1;
    end
  end

  // Raw memory data is only good on the first cycle the load is in MA
  assign ma_load_value = i_use_staged ? load_stage2 : i_ma_load_data;

  // ==========================================================
  // Operand multiplexers
  // ==========================================================

  // One mux per operand; the register file value is the fallback
  function automatic logic [FLEN-1:0] pick_operand(
    input logic [fp_fwd_pkg::SEL_W-1:0] sel,
    input logic [FLEN-1:0]              rf,
    input logic [FLEN-1:0]              ma_load,
    input logic [FLEN-1:0]              ma_result,
    input logic [FLEN-1:0]              wb,
    input logic [FLEN-1:0]              buf_data
  );
    logic [FLEN-1:0] value;
    case (sel)
      fp_fwd_pkg::SEL_MA_LOAD:   value = ma_load;
      fp_fwd_pkg::SEL_MA_RESULT: value = ma_result;
      fp_fwd_pkg::SEL_WB:        value = wb;
      fp_fwd_pkg::SEL_LOAD_BUF:  value = buf_data;
      default:                   value = rf;
    endcase
    return value;
  endfunction

  always_comb begin
    o_rs1_value = pick_operand(i_sel.rs1, i_rf_rs1, ma_load_value,
                               i_ma_result, i_wb_data, i_buf_data);
    o_rs2_value = pick_operand(i_sel.rs2, i_rf_rs2, ma_load_value,
                               i_ma_result, i_wb_data, i_buf_data);
    // The control already forces rs3 to the register file for non-FMA ops
    o_rs3_value = pick_operand(i_sel.rs3, i_rf_rs3, ma_load_value,
                               i_ma_result, i_wb_data, i_buf_data);
  end

endmodule

`default_nettype wire

/* rtl/load_capture_buf.sv */
`timescale 1ns/1ps
`default_nettype none

module load_capture_buf #(
  parameter int FLEN = 64
) (
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  fp_fwd_pkg::pipe_ctrl_t i_ctrl,
  input  fp_fwd_pkg::ma_info_t   i_ma,
  input  logic                   i_ma_load_valid,
  input  logic [FLEN-1:0]        i_ma_load_data,
  output fp_fwd_pkg::buf_tag_t   o_tag,
  output logic [FLEN-1:0]        o_data
);

  logic                             capture;
  logic                             valid;
  logic                             clear;
  logic [fp_fwd_pkg::REG_IDX_W-1:0] dest;
  logic [FLEN-1:0]                  data;

  // Any load that returns data in MA refreshes the entry
  assign capture = i_ma.is_load && i_ma_load_valid;

  // ==========================================================
  // Expiry state machine
  // ==========================================================

  // Entry lives through the first unstalled cycle after the fill, then
  // the clear flag retires it one cycle later
  always_ff @(posedge i_clk) begin
    if (i_reset || i_ctrl.flush) begin
      valid <= 1'b0;
      clear <= 1'b0;
    end else if (capture) begin
      valid <= 1'b1;
      clear <= 1'b0;
    end else if (valid) begin
      if (clear) begin
        valid <= 1'b0;
        clear <= 1'b0;
      end else if (!i_ctrl.stall) begin
        clear <= 1'b1;
      end
    end
  end

  // Payload follows the fill strobe only
  always_ff @(posedge i_clk) begin
    if (capture) begin
      dest <= i_ma.dest;
      data <= i_ma_load_data;
    end
  end

  assign o_tag.valid = valid;
  assign o_tag.dest  = dest;
  assign o_data      = data;

endmodule

`default_nettype wire
